//--- hdl/addr_gen.sv
`timescale 1ns/10ps
`include "mem_traffic_macros.svh"

module addr_gen
#(
    parameter logic [31:0] SEED       = `RD_SEED,
    parameter logic        FORCE_BIT2 = 1'b0
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     next,
    input  mem_bus_pkg::t_line_addr  base,
    input  logic                     rw_conflicts,
    output mem_bus_pkg::t_line_addr  addr,
    output logic                     checked,
    output mem_test_pkg::t_chk_idx   chk_idx
);
    import mem_bus_pkg::*;
    import mem_test_pkg::*;

    logic [31:0]  lfsr;
    t_mapped_addr mapped;

    // Galois LFSR, one step per issued request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= SEED;
        end
        else if (next)
        begin
            lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? `LFSR_TAPS : 32'h0);
        end
    end

    always_comb
    begin
        mapped = t_mapped_addr'(lfsr[$bits(t_mapped_addr)-1:0]);
        // Reads get 0 and writes get 1 here, so the two never collide
        if (!rw_conflicts)
        begin
            mapped.checked_low[2] = FORCE_BIT2;
        end
    end

    assign addr = base + t_line_addr'(mapped);

    // Only one middle pattern maps into the tag RAM
    assign checked = (mapped.unchecked_middle == '0);
    assign chk_idx = {mapped.checked_high, mapped.checked_low};

endmodule

//--- hdl/mem_bus_pkg.sv
`include "mem_traffic_macros.svh"

package mem_bus_pkg;

    // One line address and one line of data
    typedef logic [`ADDR_BITS-1:0] t_line_addr;
    typedef logic [`LINE_BITS-1:0] t_line_data;

    // Read request, checked flag rides along as metadata
    typedef struct packed
    {
        logic       valid;
        t_line_addr addr;
        logic       checked;
    } t_rd_req;

    // Full-line write request
    typedef struct packed
    {
        logic       valid;
        t_line_addr addr;
        t_line_data data;
    } t_wr_req;

    // Read response returns the metadata flag unchanged
    typedef struct packed
    {
        logic       valid;
        t_line_data data;
        logic       checked;
    } t_rd_rsp;

    // Write completion
    typedef struct packed
    {
        logic valid;
    } t_wr_rsp;

endpackage

//--- hdl/mem_test_pkg.sv
`include "mem_traffic_macros.svh"

package mem_test_pkg;

    typedef logic [`COUNTER_BITS-1:0] t_counter;
    typedef logic [`CHECKED_ADDR_BITS-1:0] t_chk_idx;

    // Compared bytes 59, 35, 13 and 0 of a line, high to low
    typedef logic [31:0] t_tag;

    // Register write strobe
    // Index 0 config and start, 1 status address, 2 region base
    typedef struct packed
    {
        logic        en;
        logic [1:0]  idx;
        logic [63:0] data;
    } t_csr_wr;

    // Low bits of a config write, flags lowest
    typedef struct packed
    {
        t_counter cycles;
        logic     enable_rw_conflicts;
        logic     enable_checker;
        logic     enable_writes;
        logic     enable_reads;
    } t_config;

    typedef enum logic [1:0]
    {
        st_idle,
        st_run,
        st_terminate,
        st_error
    } t_state;

    // Random region index split around the checked subspace
    typedef struct packed
    {
        logic [`CHECKED_ADDR_BITS-`CHECKED_LOW_BITS-1:0]      checked_high;
        logic [`MEM_REGION_BITS-`CHECKED_ADDR_BITS-1:0]       unchecked_middle;
        logic [`CHECKED_LOW_BITS-1:0]                         checked_low;
    } t_mapped_addr;

    typedef struct packed
    {
        t_state   state;
        logic     error;
        t_counter cnt_rd_rsp;
        t_counter cnt_wr_rsp;
        t_counter cnt_checked;
    } t_status;

endpackage

//--- hdl/mem_traffic_macros.svh
`ifndef MEM_TRAFFIC_MACROS_SVH
`define MEM_TRAFFIC_MACROS_SVH

// Line geometry
`define LINE_BITS 512
`define ADDR_BITS 42

// Random region, in lines
`define MEM_REGION_BITS 14

// Checked subspace, indexes the tag RAM
`define CHECKED_ADDR_BITS 10
// Low index bits taken straight from the mapped address
`define CHECKED_LOW_BITS 6

// Cycle and response counters
`define COUNTER_BITS 40

// Expected-tag FIFO
`define CHK_FIFO_DEPTH 64
`define CHK_FIFO_THRESHOLD 8

// LFSR seeds and feedback taps
`define RD_SEED 32'h0000_2721
`define WR_SEED 32'h0000_8520
`define DATA_SEED_BASE 32'h0000_0001
// x^32 + x^22 + x^2 + x + 1, right-shift Galois form
`define LFSR_TAPS 32'h8020_0003

`endif

//--- hdl/mem_traffic_top.sv
`timescale 1ns/10ps

module mem_traffic_top
(
    input  logic                  clk,
    input  logic                  reset,
    input  mem_test_pkg::t_csr_wr csr_wr,
    input  logic                  rd_alm_full,
    input  logic                  wr_alm_full,
    input  mem_bus_pkg::t_rd_rsp  rd_rsp,
    input  mem_bus_pkg::t_wr_rsp  wr_rsp,
    output mem_bus_pkg::t_rd_req  rd_req,
    output mem_bus_pkg::t_wr_req  wr_req,
    output mem_test_pkg::t_status status
);
    import mem_bus_pkg::*;
    import mem_test_pkg::*;

    t_config    cfg;
    t_line_addr mem_base;
    t_line_addr status_addr;
    logic       start_run;
    t_state     state;
    logic       chk_rdy;
    logic       chk_error;
    t_chk_idx   rd_chk_idx;
    t_chk_idx   wr_chk_idx;
    logic       wr_checked;
    t_counter   cnt_rd_rsp;
    t_counter   cnt_wr_rsp;
    t_counter   cnt_checked;

    test_control u_control
    (
        .clk,
        .reset,
        .csr_wr,
        .chk_error,
        .wr_alm_full,
        .cfg,
        .mem_base,
        .status_addr,
        .start_run,
        .state
    );

    traffic_issue u_issue
    (
        .clk,
        .reset,
        .cfg,
        .state,
        .chk_rdy,
        .rd_alm_full,
        .wr_alm_full,
        .status_addr,
        .mem_base,
        .rd_req,
        .wr_req,
        .rd_chk_idx,
        .wr_chk_idx,
        .wr_checked
    );

    tag_checker u_checker
    (
        .clk,
        .reset,
        .start_run,
        .enable_checker(cfg.enable_checker),
        .rd_req,
        .rd_chk_idx,
        .wr_req,
        .wr_chk_idx,
        .wr_checked,
        .rd_rsp,
        .wr_rsp,
        .chk_rdy,
        .error(chk_error),
        .cnt_rd_rsp,
        .cnt_wr_rsp,
        .cnt_checked
    );

    // Every field comes straight from a flop
    assign status = '{
        state:       state,
        error:       chk_error,
        cnt_rd_rsp:  cnt_rd_rsp,
        cnt_wr_rsp:  cnt_wr_rsp,
        cnt_checked: cnt_checked
    };

endmodule

//--- hdl/tag_checker.sv
`timescale 1ns/10ps
`include "mem_traffic_macros.svh"

module tag_checker
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_run,
    input  logic                   enable_checker,
    input  mem_bus_pkg::t_rd_req   rd_req,
    input  mem_test_pkg::t_chk_idx rd_chk_idx,
    input  mem_bus_pkg::t_wr_req   wr_req,
    input  mem_test_pkg::t_chk_idx wr_chk_idx,
    input  logic                   wr_checked,
    input  mem_bus_pkg::t_rd_rsp   rd_rsp,
    input  mem_bus_pkg::t_wr_rsp   wr_rsp,
    output logic                   chk_rdy,
    output logic                   error,
    output mem_test_pkg::t_counter cnt_rd_rsp,
    output mem_test_pkg::t_counter cnt_wr_rsp,
    output mem_test_pkg::t_counter cnt_checked
);
    import mem_bus_pkg::*;
    import mem_test_pkg::*;

    localparam int RAM_ENTRIES = 1 << `CHECKED_ADDR_BITS;
    localparam int PTR_BITS    = $clog2(`CHK_FIFO_DEPTH);

    // Bytes picked from a line to form its tag
    function automatic t_tag line_to_tag(t_line_data d);
        return {d[8*59 +: 8], d[8*35 +: 8], d[8*13 +: 8], d[8*0 +: 8]};
    endfunction

    t_tag tag_ram [RAM_ENTRIES];
    t_tag fifo_mem [`CHK_FIFO_DEPTH];

    t_tag              exp_tag;
    logic              push_q;
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;
    logic [PTR_BITS:0] fill;
    logic              rsp_chk;
    logic              mismatch;

    // Tag RAM starts out matching zeroed memory
    initial
    begin
        for (int i = 0; i < RAM_ENTRIES; i++)
        begin
            tag_ram[i] = '0;
        end
    end

    // ======================================
    // Tag RAM
    // ======================================
    always_ff @(posedge clk)
    begin
        if (wr_req.valid && wr_checked)
        begin
            tag_ram[wr_chk_idx] <= line_to_tag(wr_req.data);
        end
        // Same-cycle write to the same index returns old data
        exp_tag <= tag_ram[rd_chk_idx];
    end

    always_ff @(posedge clk)
    begin
        push_q <= rd_req.valid && rd_req.checked;
        if (reset)
        begin
            push_q <= 1'b0;
        end
    end

    // ======================================
    // Expected-tag FIFO
    // ======================================
    assign rsp_chk  = rd_rsp.valid && rd_rsp.checked;
    assign mismatch = line_to_tag(rd_rsp.data) != fifo_mem[rd_ptr[PTR_BITS-1:0]];
    assign fill     = wr_ptr - rd_ptr;

    always_ff @(posedge clk)
    begin
        if (push_q)
        begin
            fifo_mem[wr_ptr[PTR_BITS-1:0]] <= exp_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_q)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        // Responses come back in order, so the head is always the match
        if (rsp_chk)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        // Stop issue while the margin covers requests still in flight
        chk_rdy <= fill < (PTR_BITS+1)'(`CHK_FIFO_DEPTH - `CHK_FIFO_THRESHOLD);

        if (reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            chk_rdy <= 1'b0;
        end
    end

    // Sticky error and response counters, cleared per run
    always_ff @(posedge clk)
    begin
        if (rsp_chk && mismatch && enable_checker)
        begin
            error <= 1'b1;
        end
        cnt_rd_rsp  <= cnt_rd_rsp + t_counter'(rd_rsp.valid);
        cnt_wr_rsp  <= cnt_wr_rsp + t_counter'(wr_rsp.valid);
        cnt_checked <= cnt_checked + t_counter'(rsp_chk && enable_checker);

        if (reset || start_run)
        begin
            error       <= 1'b0;
            cnt_rd_rsp  <= '0;
            cnt_wr_rsp  <= '0;
            cnt_checked <= '0;
        end
    end

endmodule

//--- hdl/test_control.sv
`timescale 1ns/10ps

module test_control
(
    input  logic                    clk,
    input  logic                    reset,
    input  mem_test_pkg::t_csr_wr   csr_wr,
    input  logic                    chk_error,
    input  logic                    wr_alm_full,
    output mem_test_pkg::t_config   cfg,
    output mem_bus_pkg::t_line_addr mem_base,
    output mem_bus_pkg::t_line_addr status_addr,
    output logic                    start_run,
    output mem_test_pkg::t_state    state
);
    import mem_test_pkg::*;

    // Cycles left in the current run
    t_counter cycles_rem;

    // ======================================
    // Register writes
    // ======================================
    always_ff @(posedge clk)
    begin
        if (csr_wr.en)
        begin
            case (csr_wr.idx)
                2'd0: cfg <= t_config'(csr_wr.data[$bits(t_config)-1:0]);
                2'd1: status_addr <= csr_wr.data[$bits(status_addr)-1:0];
                2'd2: mem_base <= csr_wr.data[$bits(mem_base)-1:0];
                default: ;
            endcase
        end

        if (reset)
        begin
            cfg <= '0;
        end
    end

    // A config write starts a new run one cycle later
    always_ff @(posedge clk)
    begin
        start_run <= csr_wr.en && (csr_wr.idx == 2'd0);
        if (reset)
        begin
            start_run <= 1'b0;
        end
    end

    // Countdown, loaded from the captured config
    always_ff @(posedge clk)
    begin
        if (start_run)
        begin
            cycles_rem <= cfg.cycles;
        end
        else if (cycles_rem != '0)
        begin
            cycles_rem <= cycles_rem - t_counter'(1);
        end

        if (reset)
        begin
            cycles_rem <= '0;
        end
    end

    // ======================================
    // Run FSM
    // ======================================
    always_ff @(posedge clk)
    begin
        case (state)
            st_idle:
            begin
                if (start_run)
                begin
                    state <= st_run;
                end
            end
            st_run:
            begin
                // Error wins over a normal end in the same cycle
                if (chk_error)
                begin
                    state <= st_error;
                end
                else if (cycles_rem == '0)
                begin
                    state <= st_terminate;
                end
            end
            default:
            begin
                // Status write leaves in the first cycle the write side has room
                if (!wr_alm_full)
                begin
                    state <= st_idle;
                end
            end
        endcase

        if (reset)
        begin
            state <= st_idle;
        end
    end

endmodule

//--- hdl/traffic_issue.sv
`timescale 1ns/10ps
`include "mem_traffic_macros.svh"

module traffic_issue
(
    input  logic                    clk,
    input  logic                    reset,
    input  mem_test_pkg::t_config   cfg,
    input  mem_test_pkg::t_state    state,
    input  logic                    chk_rdy,
    input  logic                    rd_alm_full,
    input  logic                    wr_alm_full,
    input  mem_bus_pkg::t_line_addr status_addr,
    input  mem_bus_pkg::t_line_addr mem_base,
    output mem_bus_pkg::t_rd_req    rd_req,
    output mem_bus_pkg::t_wr_req    wr_req,
    output mem_test_pkg::t_chk_idx  rd_chk_idx,
    output mem_test_pkg::t_chk_idx  wr_chk_idx,
    output logic                    wr_checked
);
    import mem_bus_pkg::*;
    import mem_test_pkg::*;

    localparam int N_LANES = `LINE_BITS / 32;

    logic [N_LANES-1:0][31:0] lane;

    logic       rd_go;
    logic       wr_go;
    logic       status_go;
    t_line_addr rd_addr;
    t_line_addr wr_addr;
    logic       rd_checked;
    logic       wr_chk;
    t_chk_idx   rd_idx;
    t_chk_idx   wr_idx;

    // ======================================
    // Issue conditions
    // ======================================
    assign rd_go = (state == st_run) && cfg.enable_reads && chk_rdy && !rd_alm_full;
    assign wr_go = (state == st_run) && cfg.enable_writes && chk_rdy && !wr_alm_full;

    // Terminate and error both end with one status line
    assign status_go = ((state == st_terminate) || (state == st_error)) && !wr_alm_full;

    // Read addresses keep bit 2 low, write addresses keep it high
    addr_gen
    #(
        .SEED(`RD_SEED),
        .FORCE_BIT2(1'b0)
    )
    u_rd_addr
    (
        .clk,
        .reset,
        .next(rd_go),
        .base(mem_base),
        .rw_conflicts(cfg.enable_rw_conflicts),
        .addr(rd_addr),
        .checked(rd_checked),
        .chk_idx(rd_idx)
    );

    addr_gen
    #(
        .SEED(`WR_SEED),
        .FORCE_BIT2(1'b1)
    )
    u_wr_addr
    (
        .clk,
        .reset,
        .next(wr_go),
        .base(mem_base),
        .rw_conflicts(cfg.enable_rw_conflicts),
        .addr(wr_addr),
        .checked(wr_chk),
        .chk_idx(wr_idx)
    );

    // Random data, one free-running LFSR per 32-bit lane
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < N_LANES; i++)
        begin
            if (reset)
            begin
                lane[i] <= `DATA_SEED_BASE + 32'(i);
            end
            else
            begin
                lane[i] <= {1'b0, lane[i][31:1]} ^ (lane[i][0] ? `LFSR_TAPS : 32'h0);
            end
        end
    end

    // ======================================
    // Registered requests
    // ======================================
    always_ff @(posedge clk)
    begin
        rd_req.valid   <= rd_go;
        rd_req.addr    <= rd_addr;
        rd_req.checked <= rd_checked;
        rd_chk_idx     <= rd_idx;

        wr_req.valid <= wr_go;
        wr_req.addr  <= wr_addr;
        wr_req.data  <= t_line_data'(lane);
        wr_checked   <= wr_go && wr_chk;
        wr_chk_idx   <= wr_idx;

        // Status line replaces a normal write, 1 for done and 2 for error
        if (status_go)
        begin
            wr_req.valid <= 1'b1;
            wr_req.addr  <= status_addr;
            wr_req.data  <= (state == st_error) ? t_line_data'(2) : t_line_data'(1);
            wr_checked   <= 1'b0;
        end

        if (reset)
        begin
            rd_req.valid <= 1'b0;
            wr_req.valid <= 1'b0;
            wr_checked   <= 1'b0;
        end
    end

endmodule

//--- mem_traffic.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/mem_test_pkg.sv
hdl/test_control.sv
hdl/addr_gen.sv
hdl/traffic_issue.sv
hdl/tag_checker.sv
hdl/mem_traffic_top.sv
tests/tb_mem_traffic.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_traffic \
    -f mem_traffic.f -o sim_mem_traffic
./obj_dir/sim_mem_traffic > sim.log 2>&1
cat sim.log
if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

//--- tests/tb_mem_traffic.sv
`timescale 1ns/10ps
`include "mem_traffic_macros.svh"

module tb_mem_traffic;
    import mem_bus_pkg::*;
    import mem_test_pkg::*;

    localparam int REGION_LINES = 1 << `MEM_REGION_BITS;
    localparam int MID_BITS     = `MEM_REGION_BITS - `CHECKED_ADDR_BITS;
    localparam int HIGH_LSB     = `CHECKED_LOW_BITS + MID_BITS;
    localparam int RD_LAT       = 4;
    localparam int WR_LAT       = 2;

    // Programmed run lengths, in cycles
    localparam int CYC_READS   = 150;
    localparam int CYC_MIXED   = 300;
    localparam int CYC_NOCONF  = 200;
    localparam int CYC_CONF    = 200;
    localparam int CYC_CORRUPT = 300;
    localparam int CYC_WRITES  = 150;
    localparam int WATCHDOG_CYCLES = CYC_READS + CYC_MIXED + CYC_NOCONF + CYC_CONF
                                   + CYC_CORRUPT + CYC_WRITES + 200;

    logic    clk;
    logic    reset;
    t_csr_wr csr_wr;
    logic    rd_alm_full;
    logic    wr_alm_full;
    t_rd_rsp rd_rsp;
    t_wr_rsp wr_rsp;
    t_rd_req rd_req;
    t_wr_req wr_req;
    t_status status;

    // ========================================
    // Memory and reference model state
    // ========================================
    int         seed = 19;
    t_line_addr base_addr;
    t_line_addr stat_addr;
    t_line_data mem_lines [t_line_addr];
    t_tag       model_tags [1 << `CHECKED_ADDR_BITS];
    t_tag       exp_tags [$];
    t_rd_rsp    rd_pipe [RD_LAT];
    t_wr_rsp    wr_pipe [WR_LAT];

    string      test_name;
    int         errors;
    int         tests_run;
    int         tests_failed;

    // Per-run observations
    int         pending;
    int         n_rd_req;
    int         n_wr_req;
    int         n_chk_rd;
    int         pred_mismatch;
    int         out_of_region;
    int         rd_b2_set;
    int         rd_b2_clr;
    int         wr_b2_set;
    int         wr_b2_clr;
    logic       corrupt_armed;
    logic       status_seen;
    t_line_data status_data;
    t_state     end_state;

    mem_traffic_top u_dut
    (
        .clk,
        .reset,
        .csr_wr,
        .rd_alm_full,
        .wr_alm_full,
        .rd_rsp,
        .wr_rsp,
        .rd_req,
        .wr_req,
        .status
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Tag is bytes 59, 35, 13 and 0 of the line
    function automatic t_tag line_tag(t_line_data d);
        return {d[8*59 +: 8], d[8*35 +: 8], d[8*13 +: 8], d[7:0]};
    endfunction

    function automatic logic in_checked_space(t_line_addr off);
        return off[`CHECKED_LOW_BITS +: MID_BITS] == '0;
    endfunction

    function automatic t_chk_idx tag_index(t_line_addr off);
        return {off[`MEM_REGION_BITS-1:HIGH_LSB], off[`CHECKED_LOW_BITS-1:0]};
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_addr(string what, t_line_addr exp, t_line_addr act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(string what, t_line_data exp, t_line_data act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_counter(string what, t_counter exp, t_counter act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(string what, t_state exp, t_state act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %s, actual %s",
                     test_name, what, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_problem(string text);
        $display("error in %s: %s", test_name, text);
        errors++;
    endtask

    // ========================================
    // Memory model
    // ========================================
    always @(posedge clk)
    begin : mem_model
        t_line_addr off;
        t_rd_rsp    new_rd;
        t_wr_rsp    new_wr;
        logic       chk;

        // Responses delivered in the cycle that ends here
        if (rd_rsp.valid)
        begin
            pending--;
            if (rd_rsp.checked)
            begin
                if (exp_tags.size() == 0)
                begin
                    report_problem("checked read response with no expected tag");
                end
                else if (line_tag(rd_rsp.data) != exp_tags.pop_front())
                begin
                    pred_mismatch++;
                end
            end
        end
        if (wr_rsp.valid)
        begin
            pending--;
        end

        // Reads see memory before a same-cycle write
        new_rd = '0;
        if (rd_req.valid)
        begin
            off = rd_req.addr - base_addr;
            chk = in_checked_space(off);
            pending++;
            n_rd_req++;
            if (off >= t_line_addr'(REGION_LINES))
            begin
                out_of_region++;
            end
            if (off[2])
                rd_b2_set++;
            else
                rd_b2_clr++;
            check_flag("read checked flag", chk, rd_req.checked);
            if (chk)
            begin
                n_chk_rd++;
                exp_tags.push_back(model_tags[tag_index(off)]);
            end
            new_rd.valid   = 1'b1;
            new_rd.checked = rd_req.checked;
            new_rd.data    = mem_lines.exists(rd_req.addr) ? mem_lines[rd_req.addr] : '0;
            if (chk && corrupt_armed)
            begin
                new_rd.data[7:0] = ~new_rd.data[7:0];
                corrupt_armed = 1'b0;
            end
        end

        new_wr = '0;
        if (wr_req.valid)
        begin
            off = wr_req.addr - base_addr;
            pending++;
            n_wr_req++;
            // Only the status line can go out after the FSM is back in idle
            if (status.state == st_idle)
            begin
                check_addr("status address", stat_addr, wr_req.addr);
                status_seen = 1'b1;
                status_data = wr_req.data;
            end
            else
            begin
                if (off >= t_line_addr'(REGION_LINES))
                begin
                    out_of_region++;
                end
                if (off[2])
                    wr_b2_set++;
                else
                    wr_b2_clr++;
                if (in_checked_space(off))
                begin
                    model_tags[tag_index(off)] = line_tag(wr_req.data);
                end
            end
            mem_lines[wr_req.addr] = wr_req.data;
            new_wr.valid = 1'b1;
        end

        // Fixed-latency in-order return
        for (int i = RD_LAT - 1; i > 0; i--)
        begin
            rd_pipe[i] = rd_pipe[i-1];
        end
        rd_pipe[0] = new_rd;
        for (int i = WR_LAT - 1; i > 0; i--)
        begin
            wr_pipe[i] = wr_pipe[i-1];
        end
        wr_pipe[0] = new_wr;

        rd_rsp      <= rd_pipe[RD_LAT-1];
        wr_rsp      <= wr_pipe[WR_LAT-1];
        rd_alm_full <= ($random(seed) & 3) == 0;
        wr_alm_full <= ($random(seed) & 7) == 0;
    end

    // Last end-of-run state seen
    always @(negedge clk)
    begin
        if ((status.state == st_terminate) || (status.state == st_error))
        begin
            end_state = status.state;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ========================================
    // Test sequencing
    // ========================================
    task automatic write_csr(logic [1:0] idx, logic [63:0] data);
        @(posedge clk);
        csr_wr <= '{en: 1'b1, idx: idx, data: data};
        @(posedge clk);
        csr_wr <= '0;
    endtask

    // Flags are conflicts, checker, writes, reads from high to low
    task automatic run_traffic(logic [3:0] flags, int cycles, logic corrupt);
        logic exp_err;

        pending       = 0;
        n_rd_req      = 0;
        n_wr_req      = 0;
        n_chk_rd      = 0;
        pred_mismatch = 0;
        out_of_region = 0;
        rd_b2_set     = 0;
        rd_b2_clr     = 0;
        wr_b2_set     = 0;
        wr_b2_clr     = 0;
        status_seen   = 1'b0;
        end_state     = st_idle;
        corrupt_armed = corrupt;

        write_csr(2'd0, {20'h0, t_counter'(cycles), flags});
        do @(negedge clk); while (status.state != st_run);
        do @(negedge clk); while (!status_seen);
        do @(negedge clk); while (pending != 0);

        // Checks shared by every run
        exp_err = flags[2] && (pred_mismatch != 0);
        check_state("end state", exp_err ? st_error : st_terminate, end_state);
        check_state("final state", st_idle, status.state);
        check_flag("error flag", exp_err, status.error);
        check_data("status data", exp_err ? t_line_data'(2) : t_line_data'(1), status_data);
        check_counter("cnt_rd_rsp", t_counter'(n_rd_req), status.cnt_rd_rsp);
        check_counter("cnt_wr_rsp", t_counter'(n_wr_req), status.cnt_wr_rsp);
        check_counter("cnt_checked", flags[2] ? t_counter'(n_chk_rd) : '0, status.cnt_checked);
        if (out_of_region != 0)
        begin
            report_problem($sformatf("%0d request addresses fell outside the region",
                                     out_of_region));
        end
    endtask

    task automatic finish_test(int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("[%s] PASS", test_name);
        end
        else
        begin
            tests_failed++;
            $display("[%s] FAIL with %0d errors", test_name, errors - errors_before);
        end
    endtask

    initial
    begin : main
        int err_start;

        reset       = 1'b1;
        csr_wr      = '0;
        rd_alm_full = 1'b0;
        wr_alm_full = 1'b0;
        rd_rsp      = '0;
        wr_rsp      = '0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        pending     = 0;
        for (int i = 0; i < (1 << `CHECKED_ADDR_BITS); i++)
        begin
            model_tags[i] = '0;
        end
        for (int i = 0; i < RD_LAT; i++)
        begin
            rd_pipe[i] = '0;
        end
        for (int i = 0; i < WR_LAT; i++)
        begin
            wr_pipe[i] = '0;
        end
        base_addr = t_line_addr'({$random(seed), $random(seed)});
        stat_addr = base_addr + t_line_addr'(1 << 20);

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        write_csr(2'd1, 64'(stat_addr));
        write_csr(2'd2, 64'(base_addr));

        test_name = "reads_only";
        err_start = errors;
        run_traffic(4'b0101, CYC_READS, 1'b0);
        if (n_rd_req == 0)
            report_problem("no read requests were issued");
        if (n_wr_req != 1)
            report_problem("writes other than the status line were issued");
        finish_test(err_start);

        test_name = "mixed_checked";
        err_start = errors;
        run_traffic(4'b1111, CYC_MIXED, 1'b0);
        if (n_chk_rd == 0)
            report_problem("no checked reads occurred");
        finish_test(err_start);

        test_name = "bit2_rule";
        err_start = errors;
        run_traffic(4'b0111, CYC_NOCONF, 1'b0);
        check_counter("reads with bit 2 set", '0, t_counter'(rd_b2_set));
        check_counter("writes with bit 2 clear", '0, t_counter'(wr_b2_clr));
        run_traffic(4'b1111, CYC_CONF, 1'b0);
        if ((rd_b2_set == 0) || (rd_b2_clr == 0) || (wr_b2_set == 0) || (wr_b2_clr == 0))
            report_problem("with conflicts enabled, bit 2 did not take both values");
        finish_test(err_start);

        test_name = "corrupt_read";
        err_start = errors;
        run_traffic(4'b0111, CYC_CORRUPT, 1'b1);
        if (corrupt_armed)
            report_problem("no checked read was available to corrupt");
        check_state("state after corruption", st_error, end_state);
        finish_test(err_start);

        // Reads ride along with the checker off, so a bad line must not count or raise error
        test_name = "write_count";
        err_start = errors;
        run_traffic(4'b0011, CYC_WRITES, 1'b1);
        if (n_wr_req < 2)
            report_problem("no normal writes were issued");
        if (corrupt_armed)
            report_problem("no checked read was available to corrupt");
        finish_test(err_start);

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
